/* compile.f */
+incdir+include
verilog/exu_pkg.sv
verilog/alu_datapath.sv
verilog/branch_unit.sv
verilog/lsu_issue.sv
verilog/alu_exec_stage.sv
sim/tb_alu_exec_stage.sv

/* sim/exu_tests.txt */
// kind alu_op br_op mem_op src1 src2 pc imm wb_addr wb_vld expected flag
// kind 1 alu (flag wb valid), 2 branch (flag taken), 3 load/store, 4 stalled (flag bank)
1 1 0 0 00000005 00000007 00000000 00000000 01 1 0000000c 1
1 2 0 0 00000003 00000005 00000000 00000000 02 1 fffffffe 1
1 3 0 0 fffffff0 00000001 00000000 00000000 03 1 00000001 1
1 4 0 0 00000001 80000000 00000000 00000000 04 1 00000001 1
1 5 0 0 0f0f0f0f 00ff00ff 00000000 00000000 05 1 0ff00ff0 1
1 a 0 0 80000010 00000004 00000000 00000000 06 1 f8000001 1
1 c 0 0 00000000 00002000 00001000 00000000 07 0 00003000 0
1 d 0 0 00000000 00000000 00000100 00000000 08 1 00000104 1
2 0 1 0 00000005 00000005 00000200 00000010 00 0 00000210 1
2 0 2 0 00000005 00000005 00000200 00000010 00 0 00000000 0
2 0 3 0 ffffffff 00000001 00000300 fffffff8 00 0 000002f8 1
2 0 6 0 00000001 ffffffff 00000300 00000020 00 0 00000000 0
2 d 7 0 00000000 00000abc 00000400 00000000 01 1 00000ebc 1
2 d 8 0 00012340 00000004 00000500 00000000 01 1 00000344 1
3 0 0 3 00001000 00000024 00000000 00000000 0b 1 00001024 0
4 0 0 8 00002000 deadbeef 00000000 00000010 00 0 00000010 1
3 0 0 4 00004000 00000003 00000000 00000000 0c 1 00000003 2
4 0 0 7 00006000 0000cafe 00000000 00000102 00 0 00000102 3
3 0 0 2 00000ff0 00000010 00000000 00000000 0d 1 00001000 0

/* sim/tb_alu_exec_stage.sv */
`timescale 1ns/1ps

`include "exu_params.svh"

module tb_alu_exec_stage
    import exu_pkg::*;
();

    localparam int NUM_FIELD = 12;
    localparam int MAX_VEC   = 32;
    localparam int TIMEOUT   = 50;

    logic                        clk;
    logic                        rst_n;
    logic                        idu_vld;
    alu_op_e                     alu_op;
    br_op_e                      br_op;
    mem_op_e                     mem_op;
    logic [`XLEN-1:0]            src1;
    logic [`XLEN-1:0]            src2;
    logic [`XLEN-1:0]            pc;
    logic [`XLEN-1:0]            imm;
    logic                        wb_vld;
    logic [`REG_ADDR_W-1:0]      wb_addr;
    logic                        lsu_rdy;
    logic                        idu_rdy;
    logic                        idu_flush;
    logic                        idu_wb_vld;
    logic [`REG_ADDR_W-1:0]      idu_wb_addr;
    logic [`XLEN-1:0]            idu_wb_data;
    logic                        idu_ld_vld;
    logic                        br_vld;
    logic [`BR_ADDR_W-1:0]       br_addr;
    logic                        lsu_vld;
    logic                        lsu_wb_vld;
    logic [`REG_ADDR_W-1:0]      lsu_wb_addr;
    logic [`XLEN-1:0]            lsu_wb_data;
    logic [`XLEN-1:0]            lsu_src2;
    mem_op_e                     lsu_mem_op;
    logic [`SRAM_ADDR_SIZE-1:0]  lsu_ld_st_addr;
    sram_bank_e                  lsu_bank;

    logic [31:0] vec_mem [0:NUM_FIELD*MAX_VEC-1];
    logic [31:0] exp_val;
    logic [31:0] exp_flag;
    int          kind;
    int          errors;
    int          failed;
    int          ran;
    bit          aborted;

    alu_exec_stage u_alu_exec_stage (.*);

    always #5 clk = ~clk;

    task automatic check_val(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // cycles counted from the accepting edge
    task automatic wait_rise(input bit on_br, output int cycles);
        cycles = 1;
        while (!(on_br ? br_vld : lsu_vld) && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (!(on_br ? br_vld : lsu_vld)) begin
            $display("timeout: %s did not rise within %0d cycles",
                     on_br ? "br_vld" : "lsu_vld", TIMEOUT);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic apply_vector(input int v);
        int b;
        b        = v * NUM_FIELD;
        kind     = vec_mem[b];
        alu_op   = alu_op_e'(vec_mem[b+1][3:0]);
        br_op    = br_op_e'(vec_mem[b+2][3:0]);
        mem_op   = mem_op_e'(vec_mem[b+3][3:0]);
        src1     = vec_mem[b+4];
        src2     = vec_mem[b+5];
        pc       = vec_mem[b+6];
        imm      = vec_mem[b+7];
        wb_addr  = vec_mem[b+8][`REG_ADDR_W-1:0];
        wb_vld   = vec_mem[b+9][0];
        exp_val  = vec_mem[b+10];
        exp_flag = vec_mem[b+11];
        idu_vld  = 1'b1;
        lsu_rdy  = 1'b1;
    endtask

    task automatic run_branch();
        int cycles;
        if (exp_flag[0]) begin
            wait_rise(1'b1, cycles);
            if (aborted) return;
            check_val("br_vld_latency", cycles, 1);
            check_val("br_addr", br_addr, exp_val[`BR_ADDR_W-1:0]);
            // follower in the flush cycle must be dropped
            idu_vld = 1'b1;
            alu_op  = ADD;
            br_op   = BR_NONE;
            wb_vld  = 1'b1;
            @(negedge clk);
            check_val("idu_flush", idu_flush, 1);
            check_val("idu_wb_vld", idu_wb_vld, 0);
            next_cycle();
            idu_vld = 1'b0;
            check_val("br_vld", br_vld, 0);
        end else begin
            repeat (3) begin
                check_val("br_vld", br_vld, 0);
                next_cycle();
            end
        end
    endtask

    task automatic run_mem();
        int          cycles;
        int          stall_len;
        logic [63:0] ctl_snap;
        logic [63:0] data_snap;
        wait_rise(1'b0, cycles);
        if (aborted) return;
        check_val("lsu_vld_latency", cycles, 1);
        check_val("lsu_ld_st_addr", lsu_ld_st_addr, exp_val[`SRAM_ADDR_SIZE-1:0]);
        check_val("lsu_bank", lsu_bank, exp_flag[1:0]);
        check_val("lsu_mem_op", lsu_mem_op, mem_op);
        check_val("lsu_wb_vld", lsu_wb_vld, wb_vld);
        check_val("lsu_wb_addr", lsu_wb_addr, wb_addr);
        // no alu op on memory vectors
        check_val("lsu_wb_data", lsu_wb_data, 0);
        check_val("lsu_src2", lsu_src2, src2);
        if (kind != 4) return;
        // lsu stalls while a new request waits
        stall_len = 1 + ($urandom % 8);
        ctl_snap  = {lsu_vld, lsu_wb_vld, lsu_wb_addr, lsu_mem_op, lsu_bank, lsu_ld_st_addr};
        data_snap = {lsu_wb_data, lsu_src2};
        lsu_rdy   = 1'b0;
        idu_vld   = 1'b1;
        wb_vld    = 1'b1;
        src1      = src1 + 32'h100;
        repeat (stall_len) begin
            @(negedge clk);
            check_val("idu_rdy", idu_rdy, 0);
            check_val("idu_wb_vld", idu_wb_vld, 0);
            next_cycle();
            check_val("lsu_pkt_ctl", {lsu_vld, lsu_wb_vld, lsu_wb_addr, lsu_mem_op, lsu_bank,
                                      lsu_ld_st_addr}, ctl_snap);
            check_val("lsu_pkt_data", {lsu_wb_data, lsu_src2}, data_snap);
        end
        lsu_rdy = 1'b1;
        idu_vld = 1'b0;
        next_cycle();
        check_val("lsu_vld", lsu_vld, 0);
    endtask

    initial begin
        int err_start;
        clk     = 1'b0;
        rst_n   = 1'b0;
        idu_vld = 1'b0;
        alu_op  = ALU_NONE;
        br_op   = BR_NONE;
        mem_op  = MEM_NONE;
        src1    = '0;
        src2    = '0;
        pc      = '0;
        imm     = '0;
        wb_vld  = 1'b0;
        wb_addr = '0;
        lsu_rdy = 1'b1;
        errors  = 0;
        failed  = 0;
        ran     = 0;
        aborted = 1'b0;
        void'($urandom(4));
        $readmemh("sim/exu_tests.txt", vec_mem);
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_val("br_vld", br_vld, 0);
        check_val("lsu_vld", lsu_vld, 0);
        check_val("lsu_wb_vld", lsu_wb_vld, 0);
        $display("test 0 reset: %s", (errors == 0) ? "ok" : "mismatch");
        if (errors != 0) failed++;
        for (int v = 0; v < MAX_VEC && !aborted; v++) begin
            if ($isunknown(vec_mem[v*NUM_FIELD])) break;
            // idle cycle drains the previous packet
            next_cycle();
            err_start = errors;
            apply_vector(v);
            @(negedge clk);
            check_val("idu_rdy", idu_rdy, 1);
            if (kind == 1) begin
                check_val("idu_wb_vld", idu_wb_vld, exp_flag[0]);
                check_val("idu_wb_addr", idu_wb_addr, wb_addr);
                check_val("idu_wb_data", idu_wb_data, exp_val);
            end
            // loads are the first five memory codes
            check_val("idu_ld_vld", idu_ld_vld, (mem_op >= LB) && (mem_op <= LHU));
            next_cycle();
            idu_vld = 1'b0;
            if (kind == 2) begin
                run_branch();
            end else if (kind >= 3) begin
                run_mem();
            end
            ran++;
            if (errors == err_start) begin
                $display("test %0d kind %0d: ok", v + 1, kind);
            end else begin
                failed++;
                $display("test %0d kind %0d: %0d mismatches", v + 1, kind, errors - err_start);
            end
        end
        if (ran == 0) begin
            $display("no test vectors were read from sim/exu_tests.txt");
            errors++;
        end
        $display("tests run %0d, failed %0d, errors %0d", ran + 1, failed, errors);
        if (errors == 0 && !aborted) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/alu_exec_stage.sv */
`timescale 1ns/1ps

`include "exu_params.svh"

module alu_exec_stage
    import exu_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    // decode stage
    input  logic                         idu_vld,
    input  alu_op_e                      alu_op,
    input  br_op_e                       br_op,
    input  mem_op_e                      mem_op,
    input  logic [`XLEN-1:0]             src1,
    input  logic [`XLEN-1:0]             src2,
    input  logic [`XLEN-1:0]             pc,
    input  logic [`XLEN-1:0]             imm,
    input  logic                         wb_vld,
    input  logic [`REG_ADDR_W-1:0]       wb_addr,
    input  logic                         lsu_rdy,
    output logic                         idu_rdy,
    output logic                         idu_flush,
    output logic                         idu_wb_vld,
    output logic [`REG_ADDR_W-1:0]       idu_wb_addr,
    output logic [`XLEN-1:0]             idu_wb_data,
    output logic                         idu_ld_vld,
    // fetch redirect
    output logic                         br_vld,
    output logic [`BR_ADDR_W-1:0]        br_addr,
    // load/store unit
    output logic                         lsu_vld,
    output logic                         lsu_wb_vld,
    output logic [`REG_ADDR_W-1:0]       lsu_wb_addr,
    output logic [`XLEN-1:0]             lsu_wb_data,
    output logic [`XLEN-1:0]             lsu_src2,
    output mem_op_e                      lsu_mem_op,
    output logic [`SRAM_ADDR_SIZE-1:0]   lsu_ld_st_addr,
    output sram_bank_e                   lsu_bank
);

    logic accept;

    assign idu_wb_addr = wb_addr;

    alu_datapath u_alu_datapath (
        .alu_op (alu_op),
        .src1   (src1),
        .src2   (src2),
        .pc     (pc),
        .result (idu_wb_data)
    );

    branch_unit u_branch_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .idu_vld   (idu_vld),
        .lsu_rdy   (lsu_rdy),
        .br_op     (br_op),
        .src1      (src1),
        .src2      (src2),
        .pc        (pc),
        .imm       (imm),
        .accept    (accept),
        .idu_rdy   (idu_rdy),
        .idu_flush (idu_flush),
        .br_vld    (br_vld),
        .br_addr   (br_addr)
    );

    lsu_issue u_lsu_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .accept         (accept),
        .lsu_rdy        (lsu_rdy),
        .mem_op         (mem_op),
        .wb_vld         (wb_vld),
        .wb_addr        (wb_addr),
        .result         (idu_wb_data),
        .src1           (src1),
        .src2           (src2),
        .imm            (imm),
        .idu_wb_vld     (idu_wb_vld),
        .idu_ld_vld     (idu_ld_vld),
        .lsu_vld        (lsu_vld),
        .lsu_wb_vld     (lsu_wb_vld),
        .lsu_wb_addr    (lsu_wb_addr),
        .lsu_wb_data    (lsu_wb_data),
        .lsu_src2       (lsu_src2),
        .lsu_mem_op     (lsu_mem_op),
        .lsu_ld_st_addr (lsu_ld_st_addr),
        .lsu_bank       (lsu_bank)
    );

endmodule

/* verilog/lsu_issue.sv */
`timescale 1ns/1ps

`include "exu_params.svh"

module lsu_issue
    import exu_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         accept,
    input  logic                         lsu_rdy,
    input  mem_op_e                      mem_op,
    input  logic                         wb_vld,
    input  logic [`REG_ADDR_W-1:0]       wb_addr,
    input  logic [`XLEN-1:0]             result,
    input  logic [`XLEN-1:0]             src1,
    input  logic [`XLEN-1:0]             src2,
    input  logic [`XLEN-1:0]             imm,
    output logic                         idu_wb_vld,
    output logic                         idu_ld_vld,
    output logic                         lsu_vld,
    output logic                         lsu_wb_vld,
    output logic [`REG_ADDR_W-1:0]       lsu_wb_addr,
    output logic [`XLEN-1:0]             lsu_wb_data,
    output logic [`XLEN-1:0]             lsu_src2,
    output mem_op_e                      lsu_mem_op,
    output logic [`SRAM_ADDR_SIZE-1:0]   lsu_ld_st_addr,
    output sram_bank_e                   lsu_bank
);

    logic             is_load;
    logic             is_store;
    logic [`XLEN-1:0] ld_addr;
    logic [`XLEN-1:0] st_addr;
    logic [`XLEN-1:0] mem_addr;
    sram_bank_e       bank;

    assign is_load  = (mem_op inside {LB, LH, LW, LBU, LHU});
    assign is_store = (mem_op inside {SB, SH, SW});

    assign idu_wb_vld = accept & wb_vld;
    assign idu_ld_vld = is_load;

    assign ld_addr  = src1 + src2;
    assign st_addr  = src1 + imm;
    assign mem_addr = is_store ? st_addr : ld_addr;

    // bank code from address bits 14:13, 2'b11 is unmapped
    always_comb begin
        if (is_load | is_store) begin
            bank = sram_bank_e'(mem_addr[`SRAM_TYPE_LSB+1:`SRAM_TYPE_LSB]);
        end else begin
            bank = BANK_NONE;
        end
    end

    // valid bits, hold while the lsu stalls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lsu_vld    <= 1'b0;
            lsu_wb_vld <= 1'b0;
        end else if (accept) begin
            lsu_vld    <= 1'b1;
            lsu_wb_vld <= wb_vld;
        end else if (lsu_rdy) begin
            lsu_vld    <= 1'b0;
            lsu_wb_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lsu_wb_addr    <= wb_addr;
            lsu_wb_data    <= result;
            lsu_src2       <= src2;
            lsu_mem_op     <= mem_op;
            lsu_ld_st_addr <= mem_addr[`SRAM_ADDR_SIZE-1:0];
            lsu_bank       <= bank;
        end
    end

    // packet must not move under back-pressure
    a_pkt_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (lsu_vld && !lsu_rdy) |=> (lsu_vld && $stable({lsu_wb_vld, lsu_wb_addr,
            lsu_wb_data, lsu_src2, lsu_mem_op, lsu_ld_st_addr, lsu_bank})));

endmodule

/* verilog/branch_unit.sv */
`timescale 1ns/1ps

`include "exu_params.svh"

module branch_unit
    import exu_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    idu_vld,
    input  logic                    lsu_rdy,
    input  br_op_e                  br_op,
    input  logic [`XLEN-1:0]        src1,
    input  logic [`XLEN-1:0]        src2,
    input  logic [`XLEN-1:0]        pc,
    input  logic [`XLEN-1:0]        imm,
    output logic                    accept,
    output logic                    idu_rdy,
    output logic                    idu_flush,
    output logic                    br_vld,
    output logic [`BR_ADDR_W-1:0]   br_addr
);

    logic             taken;
    logic [`XLEN-1:0] br_pc;
    logic [`XLEN-1:0] jal_pc;
    logic [`XLEN-1:0] jalr_pc;
    logic [`XLEN-1:0] target;

    // instruction behind a redirect is dropped
    assign accept    = idu_vld & lsu_rdy & ~br_vld;
    assign idu_rdy   = lsu_rdy;
    assign idu_flush = br_vld;

    assign br_pc   = pc + imm;
    assign jal_pc  = pc + src2;
    assign jalr_pc = src1 + src2;

    always_comb begin
        taken  = 1'b0;
        target = '0;
        case (br_op)
            BEQ:  begin taken = (src1 == src2);                   target = br_pc; end
            BNE:  begin taken = (src1 != src2);                   target = br_pc; end
            BLT:  begin taken = ($signed(src1) < $signed(src2));  target = br_pc; end
            BGE:  begin taken = ($signed(src1) >= $signed(src2)); target = br_pc; end
            BLTU: begin taken = (src1 < src2);                    target = br_pc; end
            BGEU: begin taken = (src1 >= src2);                   target = br_pc; end
            JAL:  begin taken = 1'b1;                             target = jal_pc; end
            JALR: begin taken = 1'b1;                             target = jalr_pc; end
            default: begin
                taken  = 1'b0;
                target = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            br_vld <= 1'b0;
        end else begin
            br_vld <= accept & taken;
        end
    end

    // target register, only low bits go to fetch
    always_ff @(posedge clk) begin
        if (accept) begin
            br_addr <= target[`BR_ADDR_W-1:0];
        end
    end

    // redirect is a single-cycle pulse
    a_br_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        br_vld |=> !br_vld);

endmodule

/* verilog/alu_datapath.sv */
`timescale 1ns/1ps

`include "exu_params.svh"

module alu_datapath
    import exu_pkg::*;
(
    input  alu_op_e              alu_op,
    input  logic [`XLEN-1:0]     src1,
    input  logic [`XLEN-1:0]     src2,
    input  logic [`XLEN-1:0]     pc,
    output logic [`XLEN-1:0]     result
);

    logic [`SHAMT_W-1:0] shamt;
    logic [`XLEN-1:0]    sum;
    logic [`XLEN-1:0]    diff;
    logic [`XLEN-1:0]    lt_signed;
    logic [`XLEN-1:0]    lt_unsigned;
    logic [`XLEN-1:0]    xor_res;
    logic [`XLEN-1:0]    or_res;
    logic [`XLEN-1:0]    and_res;
    logic [`XLEN-1:0]    sll_res;
    logic [`XLEN-1:0]    srl_res;
    logic [`XLEN-1:0]    sra_res;
    logic [`XLEN-1:0]    auipc_res;
    logic [`XLEN-1:0]    link_res;

    assign shamt = src2[`SHAMT_W-1:0];

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    // full signed compare, also when the signs differ
    assign lt_signed   = {{(`XLEN-1){1'b0}}, ($signed(src1) < $signed(src2))};
    assign lt_unsigned = {{(`XLEN-1){1'b0}}, (src1 < src2)};

    assign xor_res = src1 ^ src2;
    assign or_res  = src1 | src2;
    assign and_res = src1 & src2;

    assign sll_res = src1 << shamt;
    assign srl_res = src1 >> shamt;
    assign sra_res = $signed(src1) >>> shamt;

    assign auipc_res = pc + src2;
    // return address for jal/jalr
    assign link_res  = pc + `XLEN'd4;

    always_comb begin
        case (alu_op)
            ADD:     result = sum;
            SUB:     result = diff;
            SLT:     result = lt_signed;
            SLTU:    result = lt_unsigned;
            XOR:     result = xor_res;
            OR:      result = or_res;
            AND:     result = and_res;
            SLL:     result = sll_res;
            SRL:     result = srl_res;
            SRA:     result = sra_res;
            LUI:     result = src2;
            AUIPC:   result = auipc_res;
            LINK:    result = link_res;
            default: result = '0;
        endcase
    end

endmodule

/* verilog/exu_pkg.sv */
package exu_pkg;

    // integer result select
    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,
        ADD      = 4'd1,
        SUB      = 4'd2,
        SLT      = 4'd3,
        SLTU     = 4'd4,
        XOR      = 4'd5,
        OR       = 4'd6,
        AND      = 4'd7,
        SLL      = 4'd8,
        SRL      = 4'd9,
        SRA      = 4'd10,
        LUI      = 4'd11,
        AUIPC    = 4'd12,
        LINK     = 4'd13
    } alu_op_e;

    // branch and jump kinds
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BEQ     = 4'd1,
        BNE     = 4'd2,
        BLT     = 4'd3,
        BGE     = 4'd4,
        BLTU    = 4'd5,
        BGEU    = 4'd6,
        JAL     = 4'd7,
        JALR    = 4'd8
    } br_op_e;

    // scalar memory access kinds
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        LB       = 4'd1,
        LH       = 4'd2,
        LW       = 4'd3,
        LBU      = 4'd4,
        LHU      = 4'd5,
        SB       = 4'd6,
        SH       = 4'd7,
        SW       = 4'd8
    } mem_op_e;

    // encoding matches address bits 14:13
    typedef enum logic [1:0] {
        BANK_IRAM = 2'b00,
        BANK_ORAM = 2'b01,
        BANK_WRAM = 2'b10,
        BANK_NONE = 2'b11
    } sram_bank_e;

endpackage

/* include/exu_params.svh */
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// datapath widths
`define XLEN            32
`define REG_ADDR_W      5
`define SHAMT_W         5

// low bits of the redirect target only
`define BR_ADDR_W       12

// sram word address and bank code position
`define SRAM_ADDR_SIZE  13
`define SRAM_TYPE_LSB   13

`endif
